//--- cpuPkg.sv
// Opcode in IR[15:11]; Rd or branch code in [10:8]; Ra [7:5]; Rb [4:2]; imm5 [4:0]; imm8 [7:0]
package cpuPkg;

   typedef logic [15:0] word_t;     // Data, address and instruction word
   typedef logic [2:0]  regAddr_t;

   typedef enum logic [4:0] {
      ADD    = 5'h00,
      ADDI   = 5'h01,
      SUB    = 5'h04,
      SUBI   = 5'h05,
      CMP    = 5'h06,
      AND    = 5'h08,
      OR     = 5'h09,
      XOR    = 5'h0A,
      NOT    = 5'h0B,
      LSL    = 5'h0C,             // Shift amount from imm5
      LSR    = 5'h0D,
      LUI    = 5'h10,
      LLI    = 5'h11,
      LDW    = 5'h14,
      STW    = 5'h15,
      BRANCH = 5'h18              // Kind chosen by Branch_t
   } Opcode_t;

   typedef enum logic [2:0] {
      BR  = 3'd0,
      BNE = 3'd1,
      BE  = 3'd2,
      BLT = 3'd3,
      BGE = 3'd4,
      BWL = 3'd5,
      RET = 3'd6,
      JMP = 3'd7
   } Branch_t;

   typedef enum logic [3:0] {
      FnA   = 4'd0,
      FnADD = 4'd1,
      FnSUB = 4'd2,
      FnAND = 4'd3,
      FnOR  = 4'd4,
      FnXOR = 4'd5,
      FnNOT = 4'd6,
      FnLSL = 4'd7,
      FnLSR = 4'd8,
      FnLUI = 4'd9,
      FnLLI = 4'd10
   } alu_functions_t;

   typedef enum logic {Op1Rd1, Op1Pc} Op1_select_t;
   typedef enum logic {Op2Rd2, Op2Imm} Op2_select_t;
   typedef enum logic {ImmShort, ImmLong} Imm_select_t;
   typedef enum logic {WdAlu, WdSys} Wd_select_t;
   typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus} pc_select_t;
   typedef enum logic {LrSys, LrPc} Lr_select_t;
   typedef enum logic {Rs1Ra, Rs1Rd} Rs1_select_t;

   // Bit positions in the 4-bit flag and status vectors
   parameter int FlagZ = 0;
   parameter int FlagN = 1;
   parameter int FlagV = 2;
   parameter int FlagC = 3;

endpackage

//--- alu.sv
// Purely combinational; shifts use B[3:0] only, and carry is zero for non-arithmetic functions
`timescale 1ns/10ps
module alu (
   input  cpuPkg::word_t          A,
   input  cpuPkg::word_t          B,
   input  cpuPkg::alu_functions_t Op,
   output cpuPkg::word_t          Result,
   output logic [3:0]             Flags
);
   logic [16:0] sum;
   logic [16:0] diff;
   logic        carry;
   logic        overflow;

   assign sum  = {1'b0, A} + {1'b0, B};
   assign diff = {1'b0, A} + {1'b0, ~B} + 17'd1;    // Bit 16 is not-borrow

   always_comb begin
      Result   = A;
      carry    = 1'b0;
      overflow = 1'b0;
      case (Op)
         cpuPkg::FnADD: begin
            Result   = sum[15:0];
            carry    = sum[16];
            overflow = (A[15] == B[15]) && (sum[15] != A[15]);
         end
         cpuPkg::FnSUB: begin
            Result   = diff[15:0];
            carry    = diff[16];
            overflow = (A[15] != B[15]) && (diff[15] != A[15]);
         end
         cpuPkg::FnAND: Result = A & B;
         cpuPkg::FnOR:  Result = A | B;
         cpuPkg::FnXOR: Result = A ^ B;
         cpuPkg::FnNOT: Result = ~A;
         cpuPkg::FnLSL: Result = A << B[3:0];
         cpuPkg::FnLSR: Result = A >> B[3:0];
         cpuPkg::FnLUI: Result = {B[7:0], A[7:0]};
         cpuPkg::FnLLI: Result = {A[15:8], B[7:0]};
         default:       Result = A;
      endcase
   end

   always_comb begin
      Flags                = '0;
      Flags[cpuPkg::FlagZ] = Result == '0;
      Flags[cpuPkg::FlagN] = Result[15];
      Flags[cpuPkg::FlagV] = overflow;
      Flags[cpuPkg::FlagC] = carry;
   end

endmodule

//--- regFile.sv
// Writes to register 0 are dropped so it always reads as zero; reads are combinational
`timescale 1ns/10ps
module regFile (
   input  logic             Clock,
   input  logic             nReset,
   input  cpuPkg::regAddr_t Ra1,
   input  cpuPkg::regAddr_t Ra2,
   input  cpuPkg::regAddr_t Wa,
   input  logic             We,
   input  cpuPkg::word_t    Wd,
   output cpuPkg::word_t    Rd1,
   output cpuPkg::word_t    Rd2
);
   cpuPkg::word_t regs [0:7];

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (We && (Wa != '0)) begin
         regs[Wa] <= Wd;
      end
   end

   assign Rd1 = regs[Ra1];
   assign Rd2 = regs[Ra2];

endmodule

//--- control.sv
// Fixed-timing bus with no wait states; one idle cycle follows reset before the first fetch
`timescale 1ns/10ps
module control (
   input  logic                   Clock,
   input  logic                   nReset,
   input  logic [7:0]             OpcodeCondIn,
   input  logic [3:0]             Flags,
   output cpuPkg::alu_functions_t AluOp,
   output cpuPkg::Op1_select_t    Op1Sel,
   output cpuPkg::Op2_select_t    Op2Sel,
   output cpuPkg::Imm_select_t    ImmSel,
   output cpuPkg::Wd_select_t     WdSel,
   output cpuPkg::pc_select_t     PcSel,
   output cpuPkg::Lr_select_t     LrSel,
   output cpuPkg::Rs1_select_t    Rs1Sel,
   output logic                   AluEn,
   output logic                   AluWe,
   output logic                   LrEn,
   output logic                   LrWe,
   output logic                   PcEn,
   output logic                   PcWe,
   output logic                   IrWe,
   output logic                   RegWe,
   output logic                   MemEn,
   output logic                   ENB,
   output logic                   ALE,
   output logic                   nME,
   output logic                   nOE,
   output logic                   nWE
);
   typedef enum logic [1:0] {Idle, Fetch, Execute} major_t;
   typedef enum logic [2:0] {Cycle0, Cycle1, Cycle2, Cycle3, Cycle4} sub_t;

   major_t                 majorState;
   sub_t                   subCycle;
   logic [3:0]             statusReg;
   logic                   statusWe;
   logic                   isMem;
   logic                   setsStatus;
   logic                   taken;
   cpuPkg::Opcode_t        opcode;
   cpuPkg::Branch_t        branchCode;
   cpuPkg::alu_functions_t opFn;

   assign opcode     = cpuPkg::Opcode_t'(OpcodeCondIn[7:3]);
   assign branchCode = cpuPkg::Branch_t'(OpcodeCondIn[2:0]);
   assign isMem      = (opcode == cpuPkg::LDW) || (opcode == cpuPkg::STW);

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         majorState <= Idle;
         subCycle   <= Cycle0;
         statusReg  <= '0;
      end else begin
         if (statusWe) begin
            statusReg <= Flags;
         end
         case (majorState)
            Fetch: begin
               case (subCycle)
                  Cycle0:  subCycle <= Cycle1;
                  Cycle1:  subCycle <= Cycle2;
                  Cycle2:  subCycle <= Cycle3;
                  default: begin
                     majorState <= Execute;
                     subCycle   <= Cycle0;
                  end
               endcase
            end
            Execute: begin
               case (subCycle)
                  Cycle0: begin
                     if (isMem) subCycle <= Cycle1;
                     else majorState <= Fetch;    // Single-cycle ops end here
                  end
                  Cycle1:  subCycle <= Cycle2;
                  Cycle2:  subCycle <= Cycle3;
                  Cycle3:  subCycle <= Cycle4;
                  default: begin
                     majorState <= Fetch;
                     subCycle   <= Cycle0;
                  end
               endcase
            end
            default: begin
               majorState <= Fetch;
               subCycle   <= Cycle0;
            end
         endcase
      end
   end

   // ALU function per opcode; LDW, STW and branches add
   always_comb begin
      opFn       = cpuPkg::FnADD;
      setsStatus = 1'b1;
      case (opcode)
         cpuPkg::SUB, cpuPkg::SUBI, cpuPkg::CMP: opFn = cpuPkg::FnSUB;
         cpuPkg::AND: opFn = cpuPkg::FnAND;
         cpuPkg::OR:  opFn = cpuPkg::FnOR;
         cpuPkg::XOR: opFn = cpuPkg::FnXOR;
         cpuPkg::NOT: opFn = cpuPkg::FnNOT;
         cpuPkg::LSL: opFn = cpuPkg::FnLSL;
         cpuPkg::LSR: opFn = cpuPkg::FnLSR;
         cpuPkg::ADD, cpuPkg::ADDI: opFn = cpuPkg::FnADD;
         cpuPkg::LUI: begin
            opFn       = cpuPkg::FnLUI;
            setsStatus = 1'b0;
         end
         cpuPkg::LLI: begin
            opFn       = cpuPkg::FnLLI;
            setsStatus = 1'b0;
         end
         default: setsStatus = 1'b0;
      endcase
   end

   always_comb begin
      case (branchCode)
         cpuPkg::BNE: taken = !statusReg[cpuPkg::FlagZ];
         cpuPkg::BE:  taken = statusReg[cpuPkg::FlagZ];
         cpuPkg::BLT: taken = statusReg[cpuPkg::FlagN] != statusReg[cpuPkg::FlagV];
         cpuPkg::BGE: taken = statusReg[cpuPkg::FlagN] == statusReg[cpuPkg::FlagV];
         default:     taken = 1'b1;    // BR and BWL
      endcase
   end

   always_comb begin
      AluOp    = cpuPkg::FnA;
      Op1Sel   = cpuPkg::Op1Rd1;
      Op2Sel   = cpuPkg::Op2Imm;
      ImmSel   = cpuPkg::ImmLong;
      WdSel    = cpuPkg::WdAlu;
      PcSel    = cpuPkg::Pc1;
      LrSel    = cpuPkg::LrSys;
      Rs1Sel   = cpuPkg::Rs1Ra;
      AluEn    = 1'b0;
      AluWe    = 1'b0;
      LrEn     = 1'b0;
      LrWe     = 1'b0;
      PcEn     = 1'b0;
      PcWe     = 1'b0;
      IrWe     = 1'b0;
      RegWe    = 1'b0;
      MemEn    = 1'b0;
      ENB      = 1'b0;
      ALE      = 1'b0;
      nME      = 1'b1;
      nOE      = 1'b0;
      nWE      = 1'b0;
      statusWe = 1'b0;
      case (majorState)
         Fetch: begin
            nWE   = 1'b1;
            MemEn = subCycle != Cycle0;
            case (subCycle)
               Cycle0: begin
                  ALE  = 1'b1;    // PC out as address
                  nOE  = 1'b1;
                  PcEn = 1'b1;
               end
               Cycle1: nME = 1'b0;
               Cycle2: begin
                  nME = 1'b0;
                  ENB = 1'b1;     // Capture instruction word
               end
               default: IrWe = 1'b1;
            endcase
         end
         Execute: begin
            AluOp = opFn;
            case (subCycle)
               Cycle0: begin
                  PcWe     = 1'b1;
                  statusWe = setsStatus;
                  case (opcode)
                     cpuPkg::CMP: Op2Sel = cpuPkg::Op2Rd2;
                     cpuPkg::ADD, cpuPkg::SUB, cpuPkg::AND, cpuPkg::OR, cpuPkg::XOR: begin
                        Op2Sel = cpuPkg::Op2Rd2;
                        RegWe  = 1'b1;
                     end
                     cpuPkg::ADDI, cpuPkg::SUBI, cpuPkg::LSL, cpuPkg::LSR: begin
                        ImmSel = cpuPkg::ImmShort;
                        RegWe  = 1'b1;
                     end
                     cpuPkg::NOT: RegWe = 1'b1;
                     cpuPkg::LUI, cpuPkg::LLI: begin
                        Rs1Sel = cpuPkg::Rs1Rd;   // Keep the other byte of Rd
                        RegWe  = 1'b1;
                     end
                     cpuPkg::LDW, cpuPkg::STW: begin
                        PcWe   = 1'b0;
                        ImmSel = cpuPkg::ImmShort;
                        AluWe  = 1'b1;            // Ra + imm5 into ALU output register
                     end
                     cpuPkg::BRANCH: begin
                        Op1Sel = cpuPkg::Op1Pc;
                        case (branchCode)
                           cpuPkg::RET: begin
                              LrEn  = 1'b1;
                              PcSel = cpuPkg::PcSysbus;
                           end
                           cpuPkg::JMP: begin
                              Op1Sel = cpuPkg::Op1Rd1;
                              ImmSel = cpuPkg::ImmShort;
                              PcSel  = cpuPkg::PcAluOut;
                           end
                           default: begin
                              if (taken) PcSel = cpuPkg::PcAluOut;
                              if (branchCode == cpuPkg::BWL) begin
                                 LrWe  = 1'b1;
                                 LrSel = cpuPkg::LrPc;
                              end
                           end
                        endcase
                     end
                     default: ;
                  endcase
               end
               Cycle1: begin
                  ALE   = 1'b1;   // Data address out
                  nWE   = 1'b1;
                  nOE   = 1'b1;
                  AluEn = 1'b1;
               end
               Cycle2: begin
                  nWE = 1'b1;
                  if (opcode == cpuPkg::LDW) begin
                     nME   = 1'b0;
                     MemEn = 1'b1;
                  end else begin
                     Rs1Sel = cpuPkg::Rs1Rd;   // Store data through the ALU
                     AluOp  = cpuPkg::FnA;
                     AluWe  = 1'b1;
                     AluEn  = 1'b1;
                     nOE    = 1'b1;
                  end
               end
               Cycle3: begin
                  nME = 1'b0;
                  if (opcode == cpuPkg::LDW) begin
                     nWE   = 1'b1;
                     MemEn = 1'b1;
                     ENB   = 1'b1;
                  end else begin
                     nOE   = 1'b1;
                     AluEn = 1'b1;
                  end
               end
               default: begin
                  PcWe = 1'b1;
                  nWE  = 1'b1;
                  if (opcode == cpuPkg::LDW) begin
                     MemEn = 1'b1;
                     WdSel = cpuPkg::WdSys;
                     RegWe = 1'b1;
                  end
               end
            endcase
         end
         default: ;
      endcase
   end

endmodule

//--- datapath.sv
// Bus drivers are priority-muxed (PC, ALU output, link register); BusOut is zero when none is on
`timescale 1ns/10ps
module datapath #(
   parameter cpuPkg::word_t ResetVector = 16'h0000
) (
   input  logic                   Clock,
   input  logic                   nReset,
   input  cpuPkg::alu_functions_t AluOp,
   input  cpuPkg::Op1_select_t    Op1Sel,
   input  cpuPkg::Op2_select_t    Op2Sel,
   input  cpuPkg::Imm_select_t    ImmSel,
   input  cpuPkg::Wd_select_t     WdSel,
   input  cpuPkg::pc_select_t     PcSel,
   input  cpuPkg::Lr_select_t     LrSel,
   input  cpuPkg::Rs1_select_t    Rs1Sel,
   input  logic                   AluEn,
   input  logic                   AluWe,
   input  logic                   LrEn,
   input  logic                   LrWe,
   input  logic                   PcEn,
   input  logic                   PcWe,
   input  logic                   IrWe,
   input  logic                   RegWe,
   input  logic                   MemEn,
   input  logic                   ENB,
   input  cpuPkg::word_t          DataIn,
   output cpuPkg::word_t          BusOut,
   output logic [7:0]             OpcodeCondIn,
   output logic [3:0]             Flags
);
   cpuPkg::word_t    pc;
   cpuPkg::word_t    ir;
   cpuPkg::word_t    lr;
   cpuPkg::word_t    aluOut;
   cpuPkg::word_t    sysIn;
   cpuPkg::word_t    pcPlus1;
   cpuPkg::word_t    imm;
   cpuPkg::word_t    opA;
   cpuPkg::word_t    opB;
   cpuPkg::word_t    aluResult;
   cpuPkg::word_t    rd1;
   cpuPkg::word_t    rd2;
   cpuPkg::word_t    wd;
   cpuPkg::regAddr_t rs1;

   assign pcPlus1      = pc + 16'd1;
   assign imm          = (ImmSel == cpuPkg::ImmShort) ? {{11{ir[4]}}, ir[4:0]}
                                                      : {{8{ir[7]}}, ir[7:0]};
   assign rs1          = (Rs1Sel == cpuPkg::Rs1Rd) ? ir[10:8] : ir[7:5];
   assign opA          = (Op1Sel == cpuPkg::Op1Pc) ? pcPlus1 : rd1;
   assign opB          = (Op2Sel == cpuPkg::Op2Imm) ? imm : rd2;
   assign wd           = (WdSel == cpuPkg::WdSys) ? sysIn : aluResult;
   assign OpcodeCondIn = ir[15:8];

   always_comb begin
      if (PcEn) BusOut = pc;
      else if (AluEn) BusOut = aluOut;
      else if (LrEn) BusOut = lr;
      else BusOut = '0;
   end

   regFile regFile_i (
      .Clock (Clock),
      .nReset(nReset),
      .Ra1   (rs1),
      .Ra2   (ir[4:2]),     // Rb
      .Wa    (ir[10:8]),    // Rd
      .We    (RegWe),
      .Wd    (wd),
      .Rd1   (rd1),
      .Rd2   (rd2)
   );

   alu alu_i (
      .A     (opA),
      .B     (opB),
      .Op    (AluOp),
      .Result(aluResult),
      .Flags (Flags)
   );

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         pc <= ResetVector;
      end else if (PcWe) begin
         case (PcSel)
            cpuPkg::PcAluOut: pc <= aluResult;   // Branch target or JMP address
            cpuPkg::PcSysbus: pc <= BusOut;      // RET through the link register
            default:          pc <= pcPlus1;
         endcase
      end
   end

   always_ff @(posedge Clock) begin
      if (ENB && MemEn) sysIn <= DataIn;
      if (IrWe) ir <= sysIn;
      if (AluWe) aluOut <= aluResult;
      if (LrWe) lr <= (LrSel == cpuPkg::LrPc) ? pcPlus1 : sysIn;
   end

endmodule

//--- cpuCore.sv
// ResetVector is the first fetch address; split bus with no wait states and no back-pressure
`timescale 1ns/10ps
module cpuCore #(
   parameter cpuPkg::word_t ResetVector = 16'h0000
) (
   input  logic          Clock,
   input  logic          nReset,
   input  cpuPkg::word_t DataIn,
   output cpuPkg::word_t BusOut,
   output logic          ALE,
   output logic          nME,
   output logic          nOE,
   output logic          nWE
);
   cpuPkg::alu_functions_t AluOp;
   cpuPkg::Op1_select_t    Op1Sel;
   cpuPkg::Op2_select_t    Op2Sel;
   cpuPkg::Imm_select_t    ImmSel;
   cpuPkg::Wd_select_t     WdSel;
   cpuPkg::pc_select_t     PcSel;
   cpuPkg::Lr_select_t     LrSel;
   cpuPkg::Rs1_select_t    Rs1Sel;
   logic                   AluEn;
   logic                   AluWe;
   logic                   LrEn;
   logic                   LrWe;
   logic                   PcEn;
   logic                   PcWe;
   logic                   IrWe;
   logic                   RegWe;
   logic                   MemEn;
   logic                   ENB;
   logic [7:0]             OpcodeCondIn;
   logic [3:0]             Flags;

   control control_i (.*);

   datapath #(
      .ResetVector(ResetVector)
   ) datapath_i (.*);

endmodule

//--- cpuTb.sv
// Needs ResetVector 16 and memory below 256 words; program constants come from $random with seed 50168
`timescale 1ns/10ps
module cpuTb;
   localparam cpuPkg::word_t ResetVector = 16'd16;
   localparam int AleTimeout = 12;    // Cycles allowed between two ALE pulses

   logic          Clock;
   logic          nReset;
   cpuPkg::word_t DataIn;
   cpuPkg::word_t BusOut;
   logic          ALE;
   logic          nME;
   logic          nOE;
   logic          nWE;

   cpuPkg::word_t image [0:255];      // Program image, copied into memory during reset
   cpuPkg::word_t mem [0:255];
   logic [7:0]    memAddr;
   cpuPkg::word_t trace[$];           // Expected fetch addresses in order
   logic [7:0]    expAddr[$];
   cpuPkg::word_t expData[$];
   int            wrIdx;
   int            seed;

   cpuCore #(
      .ResetVector(ResetVector)
   ) dut_i (
      .Clock (Clock),
      .nReset(nReset),
      .DataIn(DataIn),
      .BusOut(BusOut),
      .ALE   (ALE),
      .nME   (nME),
      .nOE   (nOE),
      .nWE   (nWE)
   );

   always #4 Clock = ~Clock;

   // Memory latches the address on ALE and stores on a write cycle
   always @(posedge Clock) begin
      if (!nReset) begin
         for (int i = 0; i < 256; i++) begin
            mem[i] <= image[i];
         end
      end else begin
         if (ALE) memAddr <= BusOut[7:0];
         if (!nME && !nWE) mem[memAddr] <= BusOut;
      end
   end

   assign DataIn = (!nME && !nOE) ? mem[memAddr] : '0;

   task automatic reportError(input string msg);
      $display("[ERROR] %0t ns: %s", $time, msg);
      $display("STATUS: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic reportTimeout(input string msg);
      $display("Timeout: %s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "stopped on timeout");
   endtask

   // Strobe rules and write table, checked mid-cycle
   always @(negedge Clock) begin
      if (!nReset) begin
         wrIdx <= 0;
      end else begin
         assert (!(ALE && !nME)) else reportError("nME low in an ALE cycle");
         assert (nME || nOE || nWE) else reportError("read and write strobes active together");
         if (!nME && !nWE) begin
            assert (wrIdx < expAddr.size()) else reportError("write beyond the expected table");
            assert (memAddr == expAddr[wrIdx])
               else reportError($sformatf("write address 0x%02h, expected 0x%02h",
                                          memAddr, expAddr[wrIdx]));
            assert (BusOut == expData[wrIdx])
               else reportError($sformatf("write data 0x%04h at 0x%02h, expected 0x%04h",
                                          BusOut, memAddr, expData[wrIdx]));
            wrIdx <= wrIdx + 1;
         end
      end
   end

   function automatic cpuPkg::word_t rType(input logic [4:0] op, input logic [2:0] rd,
                                           input logic [2:0] ra, input logic [2:0] rb);
      return {op, rd, ra, rb, 2'b00};
   endfunction

   function automatic cpuPkg::word_t iType(input logic [4:0] op, input logic [2:0] rd,
                                           input logic [2:0] ra, input logic [4:0] imm);
      return {op, rd, ra, imm};
   endfunction

   function automatic cpuPkg::word_t lType(input logic [4:0] op, input logic [2:0] rd,
                                           input logic [7:0] imm);
      return {op, rd, imm};
   endfunction

   function automatic logic isMemOp(input cpuPkg::word_t w);
      return (w[15:11] == cpuPkg::LDW) || (w[15:11] == cpuPkg::STW);
   endfunction

   task automatic expectWrite(input logic [7:0] addr, input cpuPkg::word_t data);
      expAddr.push_back(addr);
      expData.push_back(data);
   endtask

   // Fixed program with random operands; data area at 0xE0 through r7
   task automatic buildProgram();
      cpuPkg::word_t a;
      cpuPkg::word_t b;
      cpuPkg::word_t d;
      logic [7:0]    c;
      a = 16'($random(seed));
      b = 16'($random(seed));
      c = 8'($random(seed));
      d = 16'($random(seed));
      for (int i = 0; i < 256; i++) begin
         image[i] = {8'hEE, 8'(i)};
      end
      image[16] = lType(cpuPkg::LLI, 3'd1, a[7:0]);
      image[17] = lType(cpuPkg::LUI, 3'd1, a[15:8]);
      image[18] = lType(cpuPkg::LLI, 3'd2, b[7:0]);
      image[19] = lType(cpuPkg::LUI, 3'd2, b[15:8]);
      image[20] = lType(cpuPkg::LLI, 3'd7, 8'hE0);
      image[21] = rType(cpuPkg::ADD, 3'd3, 3'd1, 3'd2);
      image[23] = rType(cpuPkg::SUB, 3'd3, 3'd1, 3'd2);
      image[25] = rType(cpuPkg::AND, 3'd3, 3'd1, 3'd2);
      image[27] = rType(cpuPkg::OR, 3'd3, 3'd1, 3'd2);
      image[29] = rType(cpuPkg::XOR, 3'd3, 3'd1, 3'd2);
      image[31] = rType(cpuPkg::NOT, 3'd3, 3'd1, 3'd0);
      image[33] = iType(cpuPkg::LSL, 3'd3, 3'd1, 5'd5);
      image[35] = iType(cpuPkg::LSR, 3'd3, 3'd2, 5'd3);
      for (int k = 0; k < 8; k++) begin
         image[22 + 2 * k] = iType(cpuPkg::STW, 3'd3, 3'd7, 5'(k));
      end
      image[37] = iType(cpuPkg::STW, 3'd1, 3'd7, 5'd8);
      image[38] = iType(cpuPkg::STW, 3'd2, 3'd7, 5'd9);
      image[39] = lType(cpuPkg::LLI, 3'd1, c);    // Upper byte of a stays
      image[40] = iType(cpuPkg::STW, 3'd1, 3'd7, 5'd10);
      image[41] = iType(cpuPkg::LDW, 3'd4, 3'd7, 5'd15);
      image[42] = iType(cpuPkg::ADDI, 3'd4, 3'd4, 5'd1);
      image[43] = iType(cpuPkg::STW, 3'd4, 3'd7, 5'd11);
      image[44] = lType(cpuPkg::LLI, 3'd5, 8'd5);
      image[45] = lType(cpuPkg::LLI, 3'd6, 8'd9);
      image[46] = rType(cpuPkg::CMP, 3'd0, 3'd5, 3'd6);   // 5 - 9 gives N=1, Z=0, V=0
      image[47] = lType(cpuPkg::BRANCH, cpuPkg::BNE, 8'd1);
      image[49] = lType(cpuPkg::BRANCH, cpuPkg::BE, 8'd1);
      image[50] = lType(cpuPkg::BRANCH, cpuPkg::BLT, 8'd1);
      image[52] = lType(cpuPkg::BRANCH, cpuPkg::BGE, 8'd1);
      image[53] = rType(cpuPkg::CMP, 3'd0, 3'd5, 3'd5);   // Equal gives Z=1, N=0
      image[54] = lType(cpuPkg::BRANCH, cpuPkg::BNE, 8'd1);
      image[55] = lType(cpuPkg::BRANCH, cpuPkg::BE, 8'd1);
      image[57] = lType(cpuPkg::BRANCH, cpuPkg::BLT, 8'd1);
      image[58] = lType(cpuPkg::BRANCH, cpuPkg::BGE, 8'd1);
      image[60] = lType(cpuPkg::BRANCH, cpuPkg::BWL, 8'd9);   // 61 + 9 = 70
      image[61] = iType(cpuPkg::STW, 3'd3, 3'd7, 5'd12);
      image[62] = lType(cpuPkg::LLI, 3'd6, 8'd76);
      image[63] = iType(cpuPkg::BRANCH, cpuPkg::JMP, 3'd6, 5'd4);   // r6 + 4 = 80
      image[70] = iType(cpuPkg::ADDI, 3'd3, 3'd0, 5'd7);
      image[71] = lType(cpuPkg::BRANCH, cpuPkg::RET, 8'd0);
      image[80] = lType(cpuPkg::BRANCH, cpuPkg::BR, 8'hFF);    // Loops on itself
      image[239] = d;

      expectWrite(8'hE0, a + b);
      expectWrite(8'hE1, a - b);
      expectWrite(8'hE2, a & b);
      expectWrite(8'hE3, a | b);
      expectWrite(8'hE4, a ^ b);
      expectWrite(8'hE5, ~a);
      expectWrite(8'hE6, a << 5);
      expectWrite(8'hE7, b >> 3);
      expectWrite(8'hE8, a);
      expectWrite(8'hE9, b);
      expectWrite(8'hEA, {a[15:8], c});
      expectWrite(8'hEB, d + 16'd1);
      expectWrite(8'hEC, 16'd7);

      for (int i = 16; i <= 47; i++) begin
         trace.push_back(16'(i));
      end
      trace.push_back(16'd49);
      trace.push_back(16'd50);
      trace.push_back(16'd52);
      trace.push_back(16'd53);
      trace.push_back(16'd54);
      trace.push_back(16'd55);
      trace.push_back(16'd57);
      trace.push_back(16'd58);
      trace.push_back(16'd60);
      trace.push_back(16'd70);
      trace.push_back(16'd71);
      trace.push_back(16'd61);
      trace.push_back(16'd62);
      trace.push_back(16'd63);
      trace.push_back(16'd80);
      trace.push_back(16'd80);
   endtask

   // Counts cycles to the next ALE; before the first fetch no write strobe may show
   task automatic waitAle(output cpuPkg::word_t addr, output int waited, input logic idle);
      waited = 0;
      while (waited < AleTimeout) begin
         @(negedge Clock);
         waited++;
         if (ALE) begin
            addr = BusOut;
            return;
         end
         if (idle) begin
            assert (nME) else reportError("nME low before the first fetch");
         end
      end
      reportTimeout("no ALE pulse within the allowed cycles");
   endtask

   initial begin
      cpuPkg::word_t addr;
      int            waited;
      int            dataWait;
      logic          prevMem;
      Clock    = 1'b0;
      nReset  <= 1'b0;
      seed     = 50168;
      prevMem  = 1'b0;
      dataWait = 0;
      buildProgram();
      repeat (10) begin
         @(negedge Clock);
         assert (!ALE && nME) else reportError("bus strobe active during reset");
      end
      @(posedge Clock);
      nReset <= 1'b1;

      for (int i = 0; i < trace.size(); i++) begin
         waitAle(addr, waited, i == 0);
         assert (addr == trace[i])
            else reportError($sformatf("fetch address 0x%04h, expected 0x%04h", addr, trace[i]));
         if (i > 0) begin
            assert (waited + dataWait == (prevMem ? 9 : 5))
               else reportError($sformatf("%0d cycles between fetches before 0x%04h",
                                          waited + dataWait, addr));
         end
         prevMem  = isMemOp(image[addr[7:0]]);
         dataWait = 0;
         if (prevMem) begin
            waitAle(addr, dataWait, 1'b0);   // Data address phase
            assert (dataWait == 5)
               else reportError($sformatf("data ALE %0d cycles after fetch", dataWait));
         end
      end

      @(negedge Clock);
      if (wrIdx == expAddr.size()) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         reportError($sformatf("%0d writes seen, expected %0d", wrIdx, expAddr.size()));
      end
   end

endmodule

//--- verilog.f
cpuPkg.sv
alu.sv
regFile.sv
control.sv
datapath.sv
cpuCore.sv
cpuTb.sv

//--- run.sh
#!/bin/sh
# Builds and runs cpuTb with Verilator, then decides pass or fail from the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module cpuTb -o simCpu
./obj_dir/simCpu 2>&1 | tee sim.log
if grep -q "STATUS: FAIL" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
echo "simulation finished without failure"
